// ==== hw/hmc_rf_pkg.sv ====
`default_nettype none

package hmc_rf_pkg;

  // ----------------------------------------
  // register file geometry and map
  // ----------------------------------------
  localparam int unsigned RF_AWIDTH = 5;
  localparam int unsigned RF_DWIDTH = 64;

  localparam logic [RF_AWIDTH-1:0] STATUS_GENERAL_ADDR = 5'h0;
  localparam logic [RF_AWIDTH-1:0] STATUS_INIT_ADDR    = 5'h1;
  localparam logic [RF_AWIDTH-1:0] CONTROL_ADDR        = 5'h2;

  // enable to complete, in clock cycles
  localparam int unsigned RF_ACCESS_LATENCY = 2;

  // ----------------------------------------
  // control word layout
  // ----------------------------------------
  localparam int unsigned CTRL_P_RST_N_BIT   = 0;
  localparam int unsigned CTRL_INIT_CONT_BIT = 1;
  localparam int unsigned CTRL_TOKENS_LSB    = 16;
  localparam int unsigned CTRL_TOKENS_W      = 8;

  // fixed link fields, irtry counts sit at 36:32 and 44:40
  localparam logic [4:0] CTRL_IRTRY_RX_THR = 5'h10;
  localparam logic [4:0] CTRL_IRTRY_TX     = 5'h18;
  localparam logic [7:0] CTRL_RX_TOKENS    = 8'hff;
  // single mode bit at position 4, always set during bring-up
  localparam logic [RF_DWIDTH-1:0] CTRL_MODE_BITS = 64'h10;

  // release word: cube out of reset, tokens and link fields loaded
  localparam logic [RF_DWIDTH-1:0] CTRL_RELEASE_WORD =
      (64'(CTRL_IRTRY_TX) << 40) |
      (64'(CTRL_IRTRY_RX_THR) << 32) |
      (64'(CTRL_RX_TOKENS) << CTRL_TOKENS_LSB) |
      CTRL_MODE_BITS |
      (64'd1 << CTRL_P_RST_N_BIT);

  // same word, descramblers now allowed to lock
  localparam logic [RF_DWIDTH-1:0] CTRL_INIT_CONT_WORD =
      CTRL_RELEASE_WORD | (64'd1 << CTRL_INIT_CONT_BIT);

  // ----------------------------------------
  // status word views
  // ----------------------------------------
  typedef struct packed {
    logic [62:0] reserved;
    logic        link_up;
  } status_general_t;

  typedef struct packed {
    logic [14:0] reserved_hi;
    logic        all_aligned;
    logic [39:0] reserved_lo;
    logic [7:0]  lane_locked;
  } status_init_t;

  // one 64-bit read word, meaning depends on the address read
  typedef union packed {
    status_general_t status_general;
    status_init_t    status_init;
  } rf_word_u;

endpackage

`default_nettype wire

// ==== hw/hmc_init_pkg.sv ====
`default_nettype none

package hmc_init_pkg;

  // ----------------------------------------
  // bring-up FSM states
  // ----------------------------------------
  typedef enum logic [3:0] {
    RELEASE_RST,
    WAIT_REL_ACK,
    WAIT_IIC,
    SET_INIT_CONT,
    WAIT_CONT_ACK,
    READ_INIT,
    WAIT_INIT_ACK,
    READ_GENERAL,
    WAIT_GENERAL_ACK,
    DONE,
    FAIL
  } init_state_e;

  // ----------------------------------------
  // status polling bound
  // ----------------------------------------
  // completed status reads before giving up
  localparam int unsigned POLL_LIMIT = 64;
  localparam int unsigned POLL_CNT_W = 7;

  // ----------------------------------------
  // side-band done qualification
  // ----------------------------------------
  localparam int unsigned IIC_STABLE_CYCLES = 8;
  localparam int unsigned IIC_CNT_W         = 4;

endpackage

`default_nettype wire

// ==== hw/iic_done_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module iic_done_sync
  import hmc_init_pkg::*;
(
  input  wire  clk_hmc,
  input  wire  rst_i,
  input  logic iic_done_i,
  output logic iic_ready_o
);

  // two-flop synchronizer, stage 1 is the usable value
  logic [1:0]           sync_q;
  logic [IIC_CNT_W-1:0] stable_cnt_q;
  logic                 cnt_last;

  // this high cycle completes the stable window
  assign cnt_last = (stable_cnt_q == IIC_CNT_W'(IIC_STABLE_CYCLES - 1));

  always_ff @(posedge clk_hmc) begin
    if (rst_i) begin
      sync_q       <= '0;
      stable_cnt_q <= '0;
      iic_ready_o  <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], iic_done_i};
      if (!sync_q[1]) begin
        // any low cycle restarts the window and drops ready
        stable_cnt_q <= '0;
        iic_ready_o  <= 1'b0;
      end else if (stable_cnt_q != IIC_CNT_W'(IIC_STABLE_CYCLES)) begin
        // saturate once the window is full
        stable_cnt_q <= stable_cnt_q + 1'b1;
        if (cnt_last) begin
          iic_ready_o <= 1'b1;
        end
      end
    end
  end

  // ready may only rise after a full window of high synchronized samples
  a_ready_qualified : assert property (@(posedge clk_hmc) disable iff (rst_i)
    $rose(iic_ready_o) |-> $past(sync_q[1], 1) && $past(sync_q[1], IIC_STABLE_CYCLES))
    else $error("iic_ready_o rose without a stable synchronized input");

endmodule

`default_nettype wire

// ==== hw/init_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module init_sequencer
  import hmc_rf_pkg::*, hmc_init_pkg::*;
(
  input  wire                  clk_hmc,
  input  wire                  rst_i,
  input  logic                 iic_ready_i,
  output logic [RF_AWIDTH-1:0] rf_address_o,
  output logic [RF_DWIDTH-1:0] rf_write_data_o,
  output logic                 rf_write_en_o,
  output logic                 rf_read_en_o,
  input  rf_word_u             rf_read_data_i,
  input  logic                 rf_access_complete_i,
  output logic                 init_done_o,
  output logic                 init_fail_o
);

  init_state_e           state_q;
  logic [POLL_CNT_W-1:0] poll_cnt_q;
  logic                  lanes_ready;
  logic                  link_ready;
  logic                  poll_last;

  // ----------------------------------------
  // read word decode
  // ----------------------------------------
  // init view: every lane descrambler locked plus global alignment
  assign lanes_ready = (rf_read_data_i.status_init.lane_locked == 8'hff) &&
                       rf_read_data_i.status_init.all_aligned;
  // general view: link ready for traffic
  assign link_ready  = rf_read_data_i.status_general.link_up;
  // the read completing now is the last one allowed
  assign poll_last   = (poll_cnt_q == POLL_CNT_W'(POLL_LIMIT - 1));

  // ----------------------------------------
  // bring-up FSM
  // ----------------------------------------
  // enables are set on entry to an issue state and last that one cycle
  always_ff @(posedge clk_hmc) begin
    if (rst_i) begin
      state_q       <= RELEASE_RST;
      rf_write_en_o <= 1'b0;
      rf_read_en_o  <= 1'b0;
      poll_cnt_q    <= '0;
      init_done_o   <= 1'b0;
      init_fail_o   <= 1'b0;
    end else begin
      rf_write_en_o <= 1'b0;
      rf_read_en_o  <= 1'b0;
      case (state_q)
        RELEASE_RST: begin
          // first cycle out of reset raises the release write
          if (!rf_write_en_o) begin
            rf_write_en_o   <= 1'b1;
            rf_address_o    <= CONTROL_ADDR;
            rf_write_data_o <= CTRL_RELEASE_WORD;
          end else begin
            state_q <= WAIT_REL_ACK;
          end
        end
        WAIT_REL_ACK: begin
          if (rf_access_complete_i) begin
            state_q <= WAIT_IIC;
          end
        end
        WAIT_IIC: begin
          // side-band config finished, let descramblers lock
          if (iic_ready_i) begin
            rf_write_en_o   <= 1'b1;
            rf_address_o    <= CONTROL_ADDR;
            rf_write_data_o <= CTRL_INIT_CONT_WORD;
            state_q         <= SET_INIT_CONT;
          end
        end
        SET_INIT_CONT: state_q <= WAIT_CONT_ACK;
        WAIT_CONT_ACK: begin
          if (rf_access_complete_i) begin
            rf_read_en_o <= 1'b1;
            rf_address_o <= STATUS_INIT_ADDR;
            state_q      <= READ_INIT;
          end
        end
        READ_INIT: state_q <= WAIT_INIT_ACK;
        WAIT_INIT_ACK: begin
          if (rf_access_complete_i) begin
            poll_cnt_q <= poll_cnt_q + 1'b1;
            if (poll_last) begin
              init_fail_o <= 1'b1;
              state_q     <= FAIL;
            end else if (lanes_ready) begin
              // lanes are up, now ask for link state
              rf_read_en_o <= 1'b1;
              rf_address_o <= STATUS_GENERAL_ADDR;
              state_q      <= READ_GENERAL;
            end else begin
              rf_read_en_o <= 1'b1;
              rf_address_o <= STATUS_INIT_ADDR;
              state_q      <= READ_INIT;
            end
          end
        end
        READ_GENERAL: state_q <= WAIT_GENERAL_ACK;
        WAIT_GENERAL_ACK: begin
          if (rf_access_complete_i) begin
            poll_cnt_q <= poll_cnt_q + 1'b1;
            if (link_ready) begin
              // success beats the limit on the same read
              init_done_o <= 1'b1;
              state_q     <= DONE;
            end else if (poll_last) begin
              init_fail_o <= 1'b1;
              state_q     <= FAIL;
            end else begin
              // link not up yet, start over at the lane check
              rf_read_en_o <= 1'b1;
              rf_address_o <= STATUS_INIT_ADDR;
              state_q      <= READ_INIT;
            end
          end
        end
        // terminal, only reset leaves these
        DONE: state_q <= DONE;
        FAIL: state_q <= FAIL;
        default: begin
          init_fail_o <= 1'b1;
          state_q     <= FAIL;
        end
      endcase
    end
  end

  a_one_enable : assert property (@(posedge clk_hmc) disable iff (rst_i)
    !(rf_write_en_o && rf_read_en_o))
    else $error("read and write enable high together");

  // waiting on the register file means no new access may be pending
  a_no_issue_in_wait : assert property (@(posedge clk_hmc) disable iff (rst_i)
    (state_q inside {WAIT_REL_ACK, WAIT_CONT_ACK, WAIT_INIT_ACK, WAIT_GENERAL_ACK})
      |-> !(rf_write_en_o || rf_read_en_o))
    else $error("register access issued during a wait state");

endmodule

`default_nettype wire

// ==== hw/ctrl_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_regfile
  import hmc_rf_pkg::*;
(
  input  wire                      clk_hmc,
  input  wire                      rst_i,
  input  logic [RF_AWIDTH-1:0]     rf_address_i,
  input  logic [RF_DWIDTH-1:0]     rf_write_data_i,
  input  logic                     rf_write_en_i,
  input  logic                     rf_read_en_i,
  output rf_word_u                 rf_read_data_o,
  output logic                     rf_access_complete_o,
  input  logic [7:0]               lane_locked_i,
  input  logic                     lanes_aligned_i,
  input  logic                     link_up_i,
  output logic                     p_rst_n_o,
  output logic                     init_cont_set_o,
  output logic [CTRL_TOKENS_W-1:0] rx_tokens_o
);

  // one bit per cycle an access is in flight
  logic [RF_ACCESS_LATENCY-1:0] acc_pipe_q;
  logic                         acc_wr_q;
  logic [RF_DWIDTH-1:0]         ctrl_q;
  rf_word_u                     rd_word;
  logic                         acc_start;

  assign acc_start = rf_write_en_i || rf_read_en_i;

  // ----------------------------------------
  // read word assembly
  // ----------------------------------------
  always_comb begin
    // reserved fields read as zero
    rd_word = '0;
    case (rf_address_i)
      STATUS_GENERAL_ADDR: begin
        rd_word.status_general.link_up = link_up_i;
      end
      STATUS_INIT_ADDR: begin
        rd_word.status_init.lane_locked = lane_locked_i;
        rd_word.status_init.all_aligned = lanes_aligned_i;
      end
      CONTROL_ADDR: rd_word = rf_word_u'(ctrl_q);
      default: ;
    endcase
  end

  // link inputs sampled in the enable cycle, held through completion
  always_ff @(posedge clk_hmc) begin
    if (rf_read_en_i) begin
      rf_read_data_o <= rd_word;
    end
  end

  // ----------------------------------------
  // access pipeline and control register
  // ----------------------------------------
  always_ff @(posedge clk_hmc) begin
    if (rst_i) begin
      acc_pipe_q <= '0;
      acc_wr_q   <= 1'b0;
      ctrl_q     <= '0;
    end else begin
      acc_pipe_q <= {acc_pipe_q[RF_ACCESS_LATENCY-2:0], acc_start};
      if (acc_start) begin
        acc_wr_q <= rf_write_en_i;
      end
      // lands so the new value shows in the complete cycle
      if (acc_pipe_q[RF_ACCESS_LATENCY-2] && acc_wr_q && (rf_address_i == CONTROL_ADDR)) begin
        ctrl_q <= rf_write_data_i;
      end
    end
  end

  assign rf_access_complete_o = acc_pipe_q[RF_ACCESS_LATENCY-1];

  // link control pins straight off the control fields
  assign p_rst_n_o       = ctrl_q[CTRL_P_RST_N_BIT];
  assign init_cont_set_o = ctrl_q[CTRL_INIT_CONT_BIT];
  assign rx_tokens_o     = ctrl_q[CTRL_TOKENS_LSB +: CTRL_TOKENS_W];

  a_single_access : assert property (@(posedge clk_hmc) disable iff (rst_i)
    acc_start |-> (acc_pipe_q == '0))
    else $error("register access started while another is in flight");

endmodule

`default_nettype wire

// ==== hw/hmc_init_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hmc_init_top
  import hmc_rf_pkg::*;
(
  input  wire        clk_hmc,
  input  wire        rst_i,
  input  logic       iic_done_i,
  input  logic [7:0] lane_locked_i,
  input  logic       lanes_aligned_i,
  input  logic       link_up_i,
  output logic       p_rst_n_o,
  output logic       init_cont_set_o,
  output logic [7:0] rx_tokens_o,
  output logic       init_done_o,
  output logic       init_fail_o
);

  // ----------------------------------------
  // internal nets
  // ----------------------------------------
  logic                 iic_ready;
  logic [RF_AWIDTH-1:0] rf_address;
  logic [RF_DWIDTH-1:0] rf_write_data;
  logic                 rf_write_en;
  logic                 rf_read_en;
  rf_word_u             rf_read_data;
  logic                 rf_access_complete;

  // side-band done qualification
  iic_done_sync u_iic_done_sync (
    .clk_hmc     (clk_hmc),
    .rst_i       (rst_i),
    .iic_done_i  (iic_done_i),
    .iic_ready_o (iic_ready)
  );

  // bring-up FSM, sole master of the register port
  init_sequencer u_init_sequencer (
    .clk_hmc              (clk_hmc),
    .rst_i                (rst_i),
    .iic_ready_i          (iic_ready),
    .rf_address_o         (rf_address),
    .rf_write_data_o      (rf_write_data),
    .rf_write_en_o        (rf_write_en),
    .rf_read_en_o         (rf_read_en),
    .rf_read_data_i       (rf_read_data),
    .rf_access_complete_i (rf_access_complete),
    .init_done_o          (init_done_o),
    .init_fail_o          (init_fail_o)
  );

  // controller register model
  ctrl_regfile u_ctrl_regfile (
    .clk_hmc              (clk_hmc),
    .rst_i                (rst_i),
    .rf_address_i         (rf_address),
    .rf_write_data_i      (rf_write_data),
    .rf_write_en_i        (rf_write_en),
    .rf_read_en_i         (rf_read_en),
    .rf_read_data_o       (rf_read_data),
    .rf_access_complete_o (rf_access_complete),
    .lane_locked_i        (lane_locked_i),
    .lanes_aligned_i      (lanes_aligned_i),
    .link_up_i            (link_up_i),
    .p_rst_n_o            (p_rst_n_o),
    .init_cont_set_o      (init_cont_set_o),
    .rx_tokens_o          (rx_tokens_o)
  );

endmodule

`default_nettype wire

// ==== bench/tb_hmc_init.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hmc_init
  import hmc_init_pkg::*;
();

  localparam int unsigned NUM_TESTS   = 7;
  // one status read, issue to decision
  localparam int unsigned POLL_CYCLES = 3;
  localparam int unsigned WAIT_LIMIT  = POLL_LIMIT * POLL_CYCLES + 20;
  localparam int unsigned RUN_LIMIT   = NUM_TESTS * (POLL_LIMIT * POLL_CYCLES + 200);

  logic        clk_hmc = 1'b0;
  logic        rst_i;
  logic        iic_done_i;
  logic [7:0]  lane_locked_i;
  logic        lanes_aligned_i;
  logic        link_up_i;
  logic        p_rst_n_o;
  logic        init_cont_set_o;
  logic [7:0]  rx_tokens_o;
  logic        init_done_o;
  logic        init_fail_o;

  int unsigned lcg_state = 17;
  int unsigned err_cnt = 0;
  int unsigned pass_tests = 0;
  int unsigned fail_tests = 0;
  int unsigned test_num = 1;

  always #10 clk_hmc = ~clk_hmc;

  hmc_init_top DUT (
    .clk_hmc         (clk_hmc),
    .rst_i           (rst_i),
    .iic_done_i      (iic_done_i),
    .lane_locked_i   (lane_locked_i),
    .lanes_aligned_i (lanes_aligned_i),
    .link_up_i       (link_up_i),
    .p_rst_n_o       (p_rst_n_o),
    .init_cont_set_o (init_cont_set_o),
    .rx_tokens_o     (rx_tokens_o),
    .init_done_o     (init_done_o),
    .init_fail_o     (init_fail_o)
  );

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // expected final {p_rst_n, init_cont, tokens, done, fail}
  function automatic logic [11:0] expected_outputs(input bit iic_held,
      input logic [7:0] lanes, input bit aligned, input bit link,
      input int unsigned lock_poll, input int unsigned link_poll);
    bit          lanes_good;
    bit          want_general;
    int unsigned n;
    logic        done;
    logic        fail;
    lanes_good   = (lanes == 8'hff) && aligned;
    want_general = 1'b0;
    done         = 1'b0;
    // read n sees link inputs applied at poll n or earlier
    for (n = 0; n < POLL_LIMIT && !done; n++) begin
      if (want_general) begin
        // general read succeeds only once link is up
        done         = link && (n >= link_poll);
        want_general = 1'b0;
      end else begin
        // init read decides whether a general read comes next
        want_general = lanes_good && (n >= lock_poll);
      end
    end
    done = iic_held && done;
    // no success within the poll bound means failure
    fail = iic_held && !done;
    // the release write always lands, tokens come with it
    return {1'b1, iic_held, 8'hff, done, fail};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
      input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic check_outputs(input logic [11:0] exp);
    check_value("p_rst_n_o", 64'(p_rst_n_o), 64'(exp[11]));
    check_value("init_cont_set_o", 64'(init_cont_set_o), 64'(exp[10]));
    check_value("rx_tokens_o", 64'(rx_tokens_o), 64'(exp[9:2]));
    check_value("init_done_o", 64'(init_done_o), 64'(exp[1]));
    check_value("init_fail_o", 64'(init_fail_o), 64'(exp[0]));
  endtask

  // link inputs idle, all outputs must read zero while in reset
  task automatic apply_reset();
    rst_i           = 1'b1;
    iic_done_i      = 1'b0;
    lane_locked_i   = 8'h00;
    lanes_aligned_i = 1'b0;
    link_up_i       = 1'b0;
    repeat (3) begin
      @(posedge clk_hmc);
      @(negedge clk_hmc);
      check_outputs(12'h000);
    end
    rst_i = 1'b0;
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == 0) begin
      pass_tests++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      fail_tests++;
      $display("test %0d %s: %0d errors", test_num, name, err_cnt);
    end
    test_num++;
    err_cnt = 0;
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic test_reset_state();
    int unsigned waited;
    apply_reset();
    waited = 0;
    // release write completes three cycles after reset falls
    while (p_rst_n_o !== 1'b1 && waited < 3) begin
      @(negedge clk_hmc);
      waited++;
      check_value("init_cont_set_o", 64'(init_cont_set_o), 64'd0);
    end
    if (p_rst_n_o !== 1'b1) begin
      $display("p_rst_n_o did not rise within 3 cycles of reset release");
      err_cnt++;
    end
    check_outputs(expected_outputs(1'b0, 8'h00, 1'b0, 1'b0, 0, 0));
    finish_test("reset state");
  endtask

  task automatic run_scenario(input string name, input int unsigned pulses,
      input int unsigned lock_poll, input logic [7:0] lanes, input bit aligned,
      input int unsigned link_poll, input bit link);
    int unsigned len;
    int unsigned cyc;
    logic [11:0] exp;
    apply_reset();
    // glitches on config done, each shorter than the stable window
    repeat (pulses) begin
      len = 1 + lcg_next() % (IIC_STABLE_CYCLES - 2);
      iic_done_i = 1'b1;
      repeat (len) begin
        @(negedge clk_hmc);
        check_value("init_cont_set_o", 64'(init_cont_set_o), 64'd0);
      end
      iic_done_i = 1'b0;
      repeat (4 + lcg_next() % 4) begin
        @(negedge clk_hmc);
        check_value("init_cont_set_o", 64'(init_cont_set_o), 64'd0);
      end
    end
    // random delay, then hold config done
    repeat (lcg_next() % 16) begin
      @(negedge clk_hmc);
      check_value("init_cont_set_o", 64'(init_cont_set_o), 64'd0);
    end
    iic_done_i = 1'b1;
    cyc = 0;
    while (init_cont_set_o !== 1'b1 && cyc < 40) begin
      @(negedge clk_hmc);
      cyc++;
    end
    if (init_cont_set_o !== 1'b1) begin
      $display("init_cont_set_o did not rise with iic_done_i held high");
      err_cnt++;
    end
    check_value("rx_tokens_o", 64'(rx_tokens_o), 64'hff);
    // link inputs change at poll counts measured from init-continue
    cyc = 0;
    while (init_done_o !== 1'b1 && init_fail_o !== 1'b1 && cyc < WAIT_LIMIT) begin
      if (cyc == lock_poll * POLL_CYCLES) begin
        lane_locked_i   = lanes;
        lanes_aligned_i = aligned;
      end
      if (cyc == link_poll * POLL_CYCLES) begin
        link_up_i = link;
      end
      @(negedge clk_hmc);
      cyc++;
    end
    if (init_done_o !== 1'b1 && init_fail_o !== 1'b1) begin
      $display("neither init_done_o nor init_fail_o rose within %0d cycles", WAIT_LIMIT);
      err_cnt++;
    end
    exp = expected_outputs(1'b1, lanes, aligned, link, lock_poll, link_poll);
    check_outputs(exp);
    // terminal flags are sticky
    repeat (10) @(negedge clk_hmc);
    check_outputs(exp);
    finish_test(name);
  endtask

  initial begin
    int unsigned lock_poll;
    int unsigned link_poll;
    rst_i           = 1'b1;
    iic_done_i      = 1'b0;
    lane_locked_i   = 8'h00;
    lanes_aligned_i = 1'b0;
    link_up_i       = 1'b0;
    test_reset_state();
    run_scenario("qualified config done", 4, 0, 8'hff, 1'b1, 0, 1'b1);
    lock_poll = lcg_next() % 20;
    run_scenario("successful bring-up", 0, lock_poll, 8'hff, 1'b1, lock_poll, 1'b1);
    run_scenario("seven lanes locked", 0, 2, 8'h7f, 1'b1, 2, 1'b1);
    run_scenario("lanes not aligned", 0, 2, 8'hff, 1'b0, 2, 1'b1);
    run_scenario("poll timeout", 0, 1, 8'hff, 1'b1, 0, 1'b0);
    // link comes up well after lock but inside the poll bound
    lock_poll = 3;
    link_poll = lock_poll + 10 + lcg_next() % 10;
    run_scenario("late link-up", 0, lock_poll, 8'hff, 1'b1, link_poll, 1'b1);
    $display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    repeat (RUN_LIMIT) @(posedge clk_hmc);
    $display("timeout: tests did not complete within %0d cycles", RUN_LIMIT);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
hw/hmc_rf_pkg.sv
hw/hmc_init_pkg.sv
hw/iic_done_sync.sv
hw/init_sequencer.sv
hw/ctrl_regfile.sv
hw/hmc_init_top.sv
bench/tb_hmc_init.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bring-up testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_hmc_init -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
  echo "verilator build returned an error"
  exit 1
fi

./obj_dir/Vtb_hmc_init > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
exit 1
